// ==== verilog/manycore_defines.svh ====
/*
  Widths, tile count and the endpoint address map shared by the tile cluster.
  EPA values are word addresses. The instruction region must sit just above data memory.
*/
`ifndef MANYCORE_DEFINES_SVH
`define MANYCORE_DEFINES_SVH

`define DATA_WIDTH 32
`define ADDR_WIDTH 16
`define MASK_WIDTH 4

`define TILE_COUNT 4
`define TILE_ID_WIDTH 2

// 256 data words from EPA 0x0000
`define DMEM_ADDR_WIDTH 8

// pc is tag then index, region 0x0100 to 0x01FF
`define ICACHE_ADDR_WIDTH 6
`define ICACHE_TAG_WIDTH 2
`define PC_WIDTH 8

// freeze, tgo_x, tgo_y, pc_init_val at offsets 0 to 3
`define CSR_BASE 16'h2000
`define SUBCORD_WIDTH 4

`define INTR_EPA 16'h3FFF
`define INVALID_WORD 32'hDEADBEEF

`endif

// ==== verilog/manycore_pkg.sv ====
/*
  Types for the remote-access endpoint.
  The address union overlays the data-memory and instruction-store views of one EPA.
*/
`include "manycore_defines.svh"

package manycore_pkg;

  // load extension and part select, carried with every request
  typedef struct packed {
    logic is_unsigned_op;
    logic is_byte_op;
    logic is_hex_op;
    logic [1:0] part_sel;
  } load_info_s;

  typedef struct packed {
    logic [`ADDR_WIDTH-`DMEM_ADDR_WIDTH-1:0] upper;
    logic [`DMEM_ADDR_WIDTH-1:0] word_idx;
  } epa_dmem_s;

  // region flag is the bit just above the pc
  typedef struct packed {
    logic [`ADDR_WIDTH-`PC_WIDTH-2:0] upper;
    logic region;
    logic [`ICACHE_TAG_WIDTH-1:0] tag;
    logic [`ICACHE_ADDR_WIDTH-1:0] index;
  } epa_icache_s;

  typedef union packed {
    epa_dmem_s dmem;
    epa_icache_s icache;
  } epa_u;

endpackage

// ==== verilog/remote_req_if.sv ====
/*
  One remote request toward a tile and its accept strobe.
  A request is taken when v and yumi are both high; fields hold while v waits.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

interface remote_req_if;

  logic v;
  logic w;
  manycore_pkg::epa_u addr;
  logic [`DATA_WIDTH-1:0] data;
  logic [`MASK_WIDTH-1:0] mask;
  manycore_pkg::load_info_s load_info;
  logic yumi;

  modport dispatch (
    output v,
    output w,
    output addr,
    output data,
    output mask,
    output load_info,
    input  yumi
  );

  modport endpoint (
    input  v,
    input  w,
    input  addr,
    input  data,
    input  mask,
    input  load_info,
    output yumi
  );

endinterface

// ==== verilog/load_packer.sv ====
/*
  Byte and halfword extraction for loads, purely combinational.
  Halfwords use the upper part-select bit only; word loads pass through.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module load_packer (
  input  logic [`DATA_WIDTH-1:0] mem_data_i,
  input  manycore_pkg::load_info_s load_info_i,
  output logic [`DATA_WIDTH-1:0] load_data_o
);

  logic [7:0] byte_sel;
  logic [15:0] hex_sel;
  logic sign;

  assign byte_sel = mem_data_i[8*load_info_i.part_sel +: 8];
  assign hex_sel = mem_data_i[16*load_info_i.part_sel[1] +: 16];

  always_comb begin
    sign = 1'b0;
    if (load_info_i.is_byte_op) begin
      sign = ~load_info_i.is_unsigned_op & byte_sel[7];
      load_data_o = {{(`DATA_WIDTH-8){sign}}, byte_sel};
    end else if (load_info_i.is_hex_op) begin
      sign = ~load_info_i.is_unsigned_op & hex_sel[15];
      load_data_o = {{(`DATA_WIDTH-16){sign}}, hex_sel};
    end else begin
      load_data_o = mem_data_i;
    end
  end

endmodule

// ==== verilog/network_rx.sv ====
/*
  Endpoint address decode, control registers and response selection for one tile.
  Data-memory access waits on remote_dmem_yumi_i; everything else is taken at once.
  The response is valid in the cycle after acceptance.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module network_rx (
  input  logic clk_i,
  input  logic reset_i,
  remote_req_if.endpoint req,

  input  logic [`DATA_WIDTH-1:0] remote_dmem_data_i,
  input  logic remote_dmem_yumi_i,
  output logic remote_dmem_v_o,
  output logic remote_dmem_w_o,
  output logic [`DMEM_ADDR_WIDTH-1:0] remote_dmem_addr_o,
  output logic [`MASK_WIDTH-1:0] remote_dmem_mask_o,
  output logic [`DATA_WIDTH-1:0] remote_dmem_data_o,

  output logic icache_v_o,
  output logic [`PC_WIDTH-1:0] icache_pc_o,
  output logic [`DATA_WIDTH-1:0] icache_instr_o,

  output logic freeze_o,
  output logic [`SUBCORD_WIDTH-1:0] tgo_x_o,
  output logic [`SUBCORD_WIDTH-1:0] tgo_y_o,
  output logic [`PC_WIDTH-1:0] pc_init_val_o,

  output logic remote_interrupt_set_o,
  output logic remote_interrupt_clear_o,
  input  logic remote_interrupt_pending_bit_i,

  output logic [`DATA_WIDTH-1:0] returning_data_o,
  output logic returning_data_v_o
);

  // response source codes
  localparam logic [2:0] sel_zero_lp = 3'd0;
  localparam logic [2:0] sel_dmem_lp = 3'd1;
  localparam logic [2:0] sel_freeze_lp = 3'd2;
  localparam logic [2:0] sel_tgo_x_lp = 3'd3;
  localparam logic [2:0] sel_tgo_y_lp = 3'd4;
  localparam logic [2:0] sel_pc_init_lp = 3'd5;
  localparam logic [2:0] sel_intr_lp = 3'd6;
  localparam logic [2:0] sel_invalid_lp = 3'd7;

  localparam logic [`ADDR_WIDTH-1:0] csr_base_lp = `CSR_BASE;

  logic [`ADDR_WIDTH-1:0] epa;
  logic is_dmem, is_icache, is_csr, is_intr;
  logic yumi;

  logic freeze_r, freeze_n;
  logic [`SUBCORD_WIDTH-1:0] tgo_x_r, tgo_x_n;
  logic [`SUBCORD_WIDTH-1:0] tgo_y_r, tgo_y_n;
  logic [`PC_WIDTH-1:0] pc_init_val_r, pc_init_val_n;

  logic rsp_v_r;
  logic [2:0] rsp_sel_r, rsp_sel_n;
  manycore_pkg::load_info_s load_info_r;
  logic [`DATA_WIDTH-1:0] load_data;

  assign epa = req.addr;
  assign is_dmem = (req.addr.dmem.upper == '0);
  assign is_icache = req.addr.icache.region & (req.addr.icache.upper == '0);
  assign is_csr = (epa[`ADDR_WIDTH-1:2] == csr_base_lp[`ADDR_WIDTH-1:2]);
  assign is_intr = (epa == `INTR_EPA);

  // core-side fields follow the request, strobes below qualify them
  assign remote_dmem_w_o = req.w;
  assign remote_dmem_addr_o = req.addr.dmem.word_idx;
  assign remote_dmem_mask_o = req.mask;
  assign remote_dmem_data_o = req.data;
  assign icache_pc_o = {req.addr.icache.tag, req.addr.icache.index};
  assign icache_instr_o = req.data;

  assign req.yumi = yumi;

  always_comb begin
    freeze_n = freeze_r;
    tgo_x_n = tgo_x_r;
    tgo_y_n = tgo_y_r;
    pc_init_val_n = pc_init_val_r;
    rsp_sel_n = sel_zero_lp;
    yumi = 1'b0;
    remote_dmem_v_o = 1'b0;
    icache_v_o = 1'b0;
    remote_interrupt_set_o = 1'b0;
    remote_interrupt_clear_o = 1'b0;

    if (req.v) begin
      yumi = 1'b1;
      if (is_dmem) begin
        remote_dmem_v_o = 1'b1;
        yumi = remote_dmem_yumi_i;
        rsp_sel_n = req.w ? sel_zero_lp : sel_dmem_lp;
      end else if (is_icache) begin
        // instruction store is write only from the network
        icache_v_o = req.w;
        rsp_sel_n = req.w ? sel_zero_lp : sel_invalid_lp;
      end else if (is_csr) begin
        case (epa[1:0])
          2'd0: begin
            if (req.w) freeze_n = req.data[0];
            rsp_sel_n = req.w ? sel_zero_lp : sel_freeze_lp;
          end
          2'd1: begin
            if (req.w) tgo_x_n = req.data[`SUBCORD_WIDTH-1:0];
            rsp_sel_n = req.w ? sel_zero_lp : sel_tgo_x_lp;
          end
          2'd2: begin
            if (req.w) tgo_y_n = req.data[`SUBCORD_WIDTH-1:0];
            rsp_sel_n = req.w ? sel_zero_lp : sel_tgo_y_lp;
          end
          default: begin
            if (req.w) pc_init_val_n = req.data[`PC_WIDTH-1:0];
            rsp_sel_n = req.w ? sel_zero_lp : sel_pc_init_lp;
          end
        endcase
      end else if (is_intr) begin
        // write 1 sets, write 0 clears
        remote_interrupt_set_o = req.w & req.data[0];
        remote_interrupt_clear_o = req.w & ~req.data[0];
        rsp_sel_n = req.w ? sel_zero_lp : sel_intr_lp;
      end else begin
        rsp_sel_n = sel_invalid_lp;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      freeze_r <= 1'b1;
      tgo_x_r <= '0;
      tgo_y_r <= '0;
      pc_init_val_r <= '0;
      rsp_v_r <= 1'b0;
    end else begin
      freeze_r <= freeze_n;
      tgo_x_r <= tgo_x_n;
      tgo_y_r <= tgo_y_n;
      pc_init_val_r <= pc_init_val_n;
      rsp_v_r <= yumi;
    end
  end

  always_ff @(posedge clk_i) begin
    if (yumi) begin
      rsp_sel_r <= rsp_sel_n;
      load_info_r <= req.load_info;
    end
  end

  assign freeze_o = freeze_r;
  assign tgo_x_o = tgo_x_r;
  assign tgo_y_o = tgo_y_r;
  assign pc_init_val_o = pc_init_val_r;

  // memory read data arrives the cycle after acceptance
  load_packer load_packer_inst (
    .mem_data_i (remote_dmem_data_i),
    .load_info_i(load_info_r),
    .load_data_o(load_data)
  );

  assign returning_data_v_o = rsp_v_r;

  always_comb begin
    case (rsp_sel_r)
      sel_dmem_lp: returning_data_o = load_data;
      sel_freeze_lp: returning_data_o = {{(`DATA_WIDTH-1){1'b0}}, freeze_r};
      sel_tgo_x_lp: returning_data_o = {{(`DATA_WIDTH-`SUBCORD_WIDTH){1'b0}}, tgo_x_r};
      sel_tgo_y_lp: returning_data_o = {{(`DATA_WIDTH-`SUBCORD_WIDTH){1'b0}}, tgo_y_r};
      sel_pc_init_lp: returning_data_o = {{(`DATA_WIDTH-`PC_WIDTH){1'b0}}, pc_init_val_r};
      sel_intr_lp: begin
        returning_data_o = {{(`DATA_WIDTH-1){1'b0}}, remote_interrupt_pending_bit_i};
      end
      sel_invalid_lp: returning_data_o = `INVALID_WORD;
      default: returning_data_o = '0;
    endcase
  end

endmodule

// ==== verilog/tile_endpoint.sv ====
/*
  One tile: data memory, instruction store and interrupt pending bit behind network_rx.
  core_dmem_busy_i stalls remote data-memory access; instruction writes always go.
  Fetch data appears the cycle after fetch_v_i.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module tile_endpoint (
  input  logic clk_i,
  input  logic reset_i,
  remote_req_if.endpoint req,
  input  logic core_dmem_busy_i,
  input  logic fetch_v_i,
  input  logic [`PC_WIDTH-1:0] fetch_pc_i,
  output logic [`DATA_WIDTH-1:0] fetch_instr_o,
  output logic freeze_o,
  output logic rsp_v_o,
  output logic [`DATA_WIDTH-1:0] rsp_data_o
);

  logic [`DATA_WIDTH-1:0] dmem [2**`DMEM_ADDR_WIDTH];
  logic [`DATA_WIDTH-1:0] imem [2**`PC_WIDTH];

  logic dmem_v, dmem_w, dmem_yumi;
  logic [`DMEM_ADDR_WIDTH-1:0] dmem_addr;
  logic [`MASK_WIDTH-1:0] dmem_mask;
  logic [`DATA_WIDTH-1:0] dmem_wdata, dmem_rdata_r;

  logic icache_v;
  logic [`PC_WIDTH-1:0] icache_pc;
  logic [`DATA_WIDTH-1:0] icache_instr;

  logic intr_set, intr_clear, intr_pending_r;

  // core owns the port while busy
  assign dmem_yumi = ~core_dmem_busy_i;

  always_ff @(posedge clk_i) begin
    if (dmem_v & dmem_yumi) begin
      if (dmem_w) begin
        for (int b = 0; b < `MASK_WIDTH; b++) begin
          if (dmem_mask[b]) begin
            dmem[dmem_addr][8*b +: 8] <= dmem_wdata[8*b +: 8];
          end
        end
      end else begin
        dmem_rdata_r <= dmem[dmem_addr];
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (icache_v) begin
      imem[icache_pc] <= icache_instr;
    end
    if (fetch_v_i) begin
      fetch_instr_o <= imem[fetch_pc_i];
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      intr_pending_r <= 1'b0;
    end else if (intr_set) begin
      intr_pending_r <= 1'b1;
    end else if (intr_clear) begin
      intr_pending_r <= 1'b0;
    end
  end

  network_rx network_rx_inst (
    .clk_i                         (clk_i),
    .reset_i                       (reset_i),
    .req                           (req),
    .remote_dmem_data_i            (dmem_rdata_r),
    .remote_dmem_yumi_i            (dmem_yumi),
    .remote_dmem_v_o               (dmem_v),
    .remote_dmem_w_o               (dmem_w),
    .remote_dmem_addr_o            (dmem_addr),
    .remote_dmem_mask_o            (dmem_mask),
    .remote_dmem_data_o            (dmem_wdata),
    .icache_v_o                    (icache_v),
    .icache_pc_o                   (icache_pc),
    .icache_instr_o                (icache_instr),
    .freeze_o                      (freeze_o),
    .tgo_x_o                       (),
    .tgo_y_o                       (),
    .pc_init_val_o                 (),
    .remote_interrupt_set_o        (intr_set),
    .remote_interrupt_clear_o      (intr_clear),
    .remote_interrupt_pending_bit_i(intr_pending_r),
    .returning_data_o              (rsp_data_o),
    .returning_data_v_o            (rsp_v_o)
  );

endmodule

// ==== verilog/req_dispatch.sv ====
/*
  Combinational routing of the single request port to one tile.
  Only the tile named by dest_tile_i sees v; its yumi comes back as yumi_o.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module req_dispatch (
  input  logic v_i,
  input  logic w_i,
  input  logic [`TILE_ID_WIDTH-1:0] dest_tile_i,
  input  manycore_pkg::epa_u addr_i,
  input  logic [`DATA_WIDTH-1:0] data_i,
  input  logic [`MASK_WIDTH-1:0] mask_i,
  input  manycore_pkg::load_info_s load_info_i,
  output logic yumi_o,
  remote_req_if.dispatch tile_req [`TILE_COUNT]
);

  logic [`TILE_COUNT-1:0] tile_yumi;

  for (genvar g = 0; g < `TILE_COUNT; g++) begin : g_tile
    assign tile_req[g].v = v_i & (dest_tile_i == `TILE_ID_WIDTH'(g));
    // payload fans out to every tile
    assign tile_req[g].w = w_i;
    assign tile_req[g].addr = addr_i;
    assign tile_req[g].data = data_i;
    assign tile_req[g].mask = mask_i;
    assign tile_req[g].load_info = load_info_i;
    assign tile_yumi[g] = tile_req[g].yumi;
  end

  assign yumi_o = tile_yumi[dest_tile_i];

endmodule

// ==== verilog/rsp_collect.sv ====
/*
  Merges tile responses into one registered response port.
  At most one tile responds per cycle since one request is accepted per cycle.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module rsp_collect (
  input  logic clk_i,
  input  logic reset_i,
  input  logic [`TILE_COUNT-1:0] rsp_v_i,
  input  logic [`DATA_WIDTH-1:0] rsp_data_i [`TILE_COUNT],
  output logic returning_data_v_o,
  output logic [`DATA_WIDTH-1:0] returning_data_o,
  output logic [`TILE_ID_WIDTH-1:0] returning_tile_o
);

  logic [`DATA_WIDTH-1:0] data_n;
  logic [`TILE_ID_WIDTH-1:0] tile_n;

  always_comb begin
    data_n = '0;
    tile_n = '0;
    for (int t = 0; t < `TILE_COUNT; t++) begin
      if (rsp_v_i[t]) begin
        data_n = rsp_data_i[t];
        tile_n = `TILE_ID_WIDTH'(t);
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      returning_data_v_o <= 1'b0;
    end else begin
      returning_data_v_o <= |rsp_v_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (|rsp_v_i) begin
      returning_data_o <= data_n;
      returning_tile_o <= tile_n;
    end
  end

endmodule

// ==== verilog/tile_array_top.sv ====
/*
  Four-tile remote-access cluster with one request port and one response port.
  A response follows acceptance by two cycles; there is no response back-pressure.
  fetch_instr_o shows the addressed tile's instruction one cycle after fetch_pc_i.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module tile_array_top (
  input  logic clk_i,
  input  logic reset_i,

  input  logic v_i,
  input  logic w_i,
  input  logic [`TILE_ID_WIDTH-1:0] dest_tile_i,
  input  logic [`ADDR_WIDTH-1:0] addr_i,
  input  logic [`DATA_WIDTH-1:0] data_i,
  input  logic [`MASK_WIDTH-1:0] mask_i,
  input  logic load_unsigned_i,
  input  logic load_byte_i,
  input  logic load_hex_i,
  input  logic [1:0] load_part_sel_i,
  output logic yumi_o,

  output logic [`DATA_WIDTH-1:0] returning_data_o,
  output logic returning_data_v_o,
  output logic [`TILE_ID_WIDTH-1:0] returning_tile_o,

  input  logic [`TILE_COUNT-1:0] core_dmem_busy_i,
  input  logic [`TILE_ID_WIDTH-1:0] fetch_tile_i,
  input  logic [`PC_WIDTH-1:0] fetch_pc_i,
  output logic [`DATA_WIDTH-1:0] fetch_instr_o,
  output logic [`TILE_COUNT-1:0] freeze_o
);

  manycore_pkg::load_info_s load_info;
  logic [`TILE_COUNT-1:0] rsp_v;
  logic [`DATA_WIDTH-1:0] rsp_data [`TILE_COUNT];
  logic [`DATA_WIDTH-1:0] fetch_instr [`TILE_COUNT];
  logic [`TILE_ID_WIDTH-1:0] fetch_tile_r;

  remote_req_if tile_req [`TILE_COUNT] ();

  assign load_info = '{
    is_unsigned_op: load_unsigned_i,
    is_byte_op: load_byte_i,
    is_hex_op: load_hex_i,
    part_sel: load_part_sel_i
  };

  req_dispatch req_dispatch_inst (
    .v_i        (v_i),
    .w_i        (w_i),
    .dest_tile_i(dest_tile_i),
    .addr_i     (addr_i),
    .data_i     (data_i),
    .mask_i     (mask_i),
    .load_info_i(load_info),
    .yumi_o     (yumi_o),
    .tile_req   (tile_req)
  );

  for (genvar g = 0; g < `TILE_COUNT; g++) begin : g_tile
    tile_endpoint tile_endpoint_inst (
      .clk_i           (clk_i),
      .reset_i         (reset_i),
      .req             (tile_req[g]),
      .core_dmem_busy_i(core_dmem_busy_i[g]),
      .fetch_v_i       (fetch_tile_i == `TILE_ID_WIDTH'(g)),
      .fetch_pc_i      (fetch_pc_i),
      .fetch_instr_o   (fetch_instr[g]),
      .freeze_o        (freeze_o[g]),
      .rsp_v_o         (rsp_v[g]),
      .rsp_data_o      (rsp_data[g])
    );
  end

  // tile select lines up with the registered fetch data
  always_ff @(posedge clk_i) begin
    fetch_tile_r <= fetch_tile_i;
  end

  assign fetch_instr_o = fetch_instr[fetch_tile_r];

  rsp_collect rsp_collect_inst (
    .clk_i             (clk_i),
    .reset_i           (reset_i),
    .rsp_v_i           (rsp_v),
    .rsp_data_i        (rsp_data),
    .returning_data_v_o(returning_data_v_o),
    .returning_data_o  (returning_data_o),
    .returning_tile_o  (returning_tile_o)
  );

endmodule

// ==== testbench/tile_array_asserts.sv ====
/*
  Protocol assertions on the cluster's request and response ports, bound to the top level.
  fail_count holds the number of assertion failures seen so far.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module tile_array_asserts (
  input logic clk_i,
  input logic reset_i,
  input logic v_i,
  input logic w_i,
  input logic [`TILE_ID_WIDTH-1:0] dest_tile_i,
  input logic [`ADDR_WIDTH-1:0] addr_i,
  input logic [`DATA_WIDTH-1:0] data_i,
  input logic [`MASK_WIDTH-1:0] mask_i,
  input logic load_unsigned_i,
  input logic load_byte_i,
  input logic load_hex_i,
  input logic [1:0] load_part_sel_i,
  input logic yumi_o,
  input logic returning_data_v_o
);

  int fail_count = 0;
  logic [59:0] req_fields;

  assign req_fields = {w_i, dest_tile_i, addr_i, data_i, mask_i,
                       load_unsigned_i, load_byte_i, load_hex_i, load_part_sel_i};

  yumi_needs_v: assert property (@(posedge clk_i) disable iff (reset_i) yumi_o |-> v_i)
    else begin
      fail_count++;
      $error("yumi_o high without v_i");
    end

  // a waiting request keeps v and every field
  req_held: assert property (@(posedge clk_i) disable iff (reset_i)
    (v_i && !yumi_o) |=> (v_i && $stable(req_fields)))
    else begin
      fail_count++;
      $error("request dropped or changed while waiting for yumi_o");
    end

  rsp_two_cycles: assert property (@(posedge clk_i) disable iff (reset_i)
    returning_data_v_o == $past(v_i && yumi_o, 2))
    else begin
      fail_count++;
      $error("returning_data_v_o does not follow acceptance by two cycles");
    end

endmodule

bind tile_array_top tile_array_asserts tile_array_asserts_inst (
  .clk_i             (clk_i),
  .reset_i           (reset_i),
  .v_i               (v_i),
  .w_i               (w_i),
  .dest_tile_i       (dest_tile_i),
  .addr_i            (addr_i),
  .data_i            (data_i),
  .mask_i            (mask_i),
  .load_unsigned_i   (load_unsigned_i),
  .load_byte_i       (load_byte_i),
  .load_hex_i        (load_hex_i),
  .load_part_sel_i   (load_part_sel_i),
  .yumi_o            (yumi_o),
  .returning_data_v_o(returning_data_v_o)
);

// ==== testbench/tile_array_tb.sv ====
/*
  Directed tests for the four-tile cluster against a model of memory and registers.
  One request is in flight at a time; responses are checked two cycles after acceptance.
*/
`timescale 1ns/1ps
`include "manycore_defines.svh"

module tile_array_tb;

  localparam int timeout_lp = 100;
  localparam int busy_cycles_lp = 20;

  logic clk = 1'b0;
  logic reset;
  logic v, w;
  logic [1:0] dest_tile;
  logic [15:0] addr;
  logic [31:0] data;
  logic [3:0] mask;
  logic [4:0] ld;
  logic yumi;
  logic [31:0] rsp_data;
  logic rsp_v;
  logic [1:0] rsp_tile;
  logic [3:0] busy;
  logic [1:0] fetch_tile;
  logic [7:0] fetch_pc;
  logic [31:0] fetch_instr;
  logic [3:0] freeze;

  // reference model per tile
  logic [31:0] dmem_model [4][256];
  logic [3:0] freeze_model;
  logic [3:0] tgo_x_model [4];
  logic [3:0] tgo_y_model [4];
  logic [7:0] pc_init_model [4];
  logic [3:0] pending_model;

  int errors = 0;
  int checks = 0;

  always #4 clk = ~clk;

  tile_array_top tile_array_top_inst (
    .clk_i(clk), .reset_i(reset),
    .v_i(v), .w_i(w), .dest_tile_i(dest_tile), .addr_i(addr), .data_i(data), .mask_i(mask),
    .load_unsigned_i(ld[4]), .load_byte_i(ld[3]), .load_hex_i(ld[2]),
    .load_part_sel_i(ld[1:0]), .yumi_o(yumi),
    .returning_data_o(rsp_data), .returning_data_v_o(rsp_v), .returning_tile_o(rsp_tile),
    .core_dmem_busy_i(busy), .fetch_tile_i(fetch_tile), .fetch_pc_i(fetch_pc),
    .fetch_instr_o(fetch_instr), .freeze_o(freeze)
  );

  task automatic check_value(input string what, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp)
      else begin
        errors++;
        $display("FAILED at %0t: %s got %h, expected %h", $time, what, got, exp);
      end
  endtask

  task automatic report_counts();
    int afails;
    afails = tile_array_top_inst.tile_array_asserts_inst.fail_count;
    $display("checks: %0d, errors: %0d, assertion failures: %0d", checks, errors, afails);
  endtask

  // byte or halfword pick with sign or zero fill
  // ld packs unsigned, byte, hex and part select
  function automatic logic [31:0] expect_load(input logic [31:0] word, input logic [4:0] l);
    logic [7:0] b;
    logic [15:0] h;
    b = word >> (8 * l[1:0]);
    h = l[1] ? word[31:16] : word[15:0];
    if (l[3]) return l[4] ? {24'h0, b} : {{24{b[7]}}, b};
    if (l[2]) return l[4] ? {16'h0, h} : {{16{h[15]}}, h};
    return word;
  endfunction

  task automatic drive_req(input int tile, input logic wr, input logic [15:0] a,
                           input logic [31:0] d, input logic [3:0] m, input logic [4:0] l);
    @(posedge clk);
    #1;
    v = 1'b1;
    w = wr;
    dest_tile = tile[1:0];
    addr = a;
    data = d;
    mask = m;
    ld = l;
  endtask

  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!yumi && n < timeout_lp) begin
      n++;
      @(negedge clk);
    end
    if (!yumi) begin
      errors++;
      $display("request to tile %0d at EPA %h was never accepted", dest_tile, addr);
      report_counts();
      $display("FAIL: see errors above");
      $finish;
    end else begin
      // acceptance edge
      @(posedge clk);
      #1;
      v = 1'b0;
    end
  endtask

  task automatic check_rsp(input int tile, input logic [31:0] exp, input string what);
    @(posedge clk);
    @(negedge clk);
    check_value({what, " valid"}, 32'(rsp_v), 32'd1);
    check_value({what, " data"}, rsp_data, exp);
    check_value({what, " tile"}, 32'(rsp_tile), 32'(tile));
  endtask

  task automatic send(input int tile, input logic wr, input logic [15:0] a, input logic [31:0] d,
                      input logic [3:0] m, input logic [4:0] l, input logic [31:0] exp,
                      input string what);
    drive_req(tile, wr, a, d, m, l);
    wait_accept();
    check_rsp(tile, exp, what);
  endtask

  task automatic write_dmem(input int tile, input logic [7:0] a, input logic [31:0] d,
                            input logic [3:0] m);
    for (int b = 0; b < 4; b++) begin
      if (m[b]) dmem_model[tile][a][8*b +: 8] = d[8*b +: 8];
    end
    send(tile, 1'b1, {8'h0, a}, d, m, 5'b0, 32'h0, "dmem write");
  endtask

  task automatic reset_state_test();
    @(negedge clk);
    check_value("freeze_o after reset", 32'(freeze), 32'hF);
    for (int t = 0; t < 4; t++) begin
      send(t, 1'b0, `CSR_BASE, 0, 0, 0, 32'd1, "freeze read");
      send(t, 1'b0, `CSR_BASE + 1, 0, 0, 0, 32'd0, "tgo_x read");
      send(t, 1'b0, `CSR_BASE + 2, 0, 0, 0, 32'd0, "tgo_y read");
      send(t, 1'b0, `CSR_BASE + 3, 0, 0, 0, 32'd0, "pc_init_val read");
      send(t, 1'b0, `INTR_EPA, 0, 0, 0, 32'd0, "pending read");
    end
  endtask

  task automatic dmem_word_test();
    logic [7:0] a;
    for (int t = 0; t < 4; t++) begin
      for (int k = 0; k < 6; k++) begin
        a = 8'(16 * k + 3 * t + 1);
        write_dmem(t, a, $urandom(), 4'hF);
      end
      for (int k = 0; k < 6; k++) begin
        a = 8'(16 * k + 3 * t + 1);
        send(t, 1'b0, {8'h0, a}, 0, 0, 0, dmem_model[t][a], "dmem word read");
      end
    end
  endtask

  task automatic load_ext_test();
    logic [4:0] l;
    write_dmem(2, 8'h40, 32'h8C7F_F001, 4'hF);
    write_dmem(2, 8'h41, $urandom(), 4'hF);
    write_dmem(2, 8'h41, $urandom(), 4'b1001);
    for (int a = 8'h40; a <= 8'h41; a++) begin
      for (int p = 0; p < 4; p++) begin
        for (int u = 0; u < 2; u++) begin
          l = {u[0], 1'b1, 1'b0, p[1:0]};
          send(2, 1'b0, 16'(a), 0, 0, l, expect_load(dmem_model[2][a], l), "byte load");
          l = {u[0], 1'b0, 1'b1, p[1:0]};
          send(2, 1'b0, 16'(a), 0, 0, l, expect_load(dmem_model[2][a], l), "halfword load");
        end
      end
    end
  endtask

  task automatic csr_test();
    for (int t = 0; t < 4; t++) begin
      tgo_x_model[t] = 4'(t + 5);
      tgo_y_model[t] = 4'($urandom());
      pc_init_model[t] = 8'($urandom());
      send(t, 1'b1, `CSR_BASE + 1, 32'(tgo_x_model[t]), 4'hF, 0, 32'h0, "tgo_x write");
      send(t, 1'b1, `CSR_BASE + 2, 32'(tgo_y_model[t]), 4'hF, 0, 32'h0, "tgo_y write");
      send(t, 1'b1, `CSR_BASE + 3, 32'(pc_init_model[t]), 4'hF, 0, 32'h0, "pc_init write");
      send(t, 1'b0, `CSR_BASE + 1, 0, 0, 0, 32'(tgo_x_model[t]), "tgo_x read");
      send(t, 1'b0, `CSR_BASE + 2, 0, 0, 0, 32'(tgo_y_model[t]), "tgo_y read");
      send(t, 1'b0, `CSR_BASE + 3, 0, 0, 0, 32'(pc_init_model[t]), "pc_init read");
    end
    freeze_model[1] = 1'b0;
    send(1, 1'b1, `CSR_BASE, 32'h0, 4'hF, 0, 32'h0, "freeze write");
    check_value("freeze_o after unfreeze", 32'(freeze), 32'(freeze_model));
    send(1, 1'b0, `CSR_BASE, 0, 0, 0, 32'(freeze_model[1]), "freeze read");
    pending_model[3] = 1'b1;
    send(3, 1'b1, `INTR_EPA, 32'h1, 4'hF, 0, 32'h0, "pending set");
    send(3, 1'b0, `INTR_EPA, 0, 0, 0, 32'(pending_model[3]), "pending read");
    pending_model[3] = 1'b0;
    send(3, 1'b1, `INTR_EPA, 32'h0, 4'hF, 0, 32'h0, "pending clear");
    send(3, 1'b0, `INTR_EPA, 0, 0, 0, 32'(pending_model[3]), "pending read");
  endtask

  task automatic invalid_and_icache_test();
    logic [31:0] instr;
    instr = $urandom();
    send(0, 1'b0, 16'h1000, 0, 0, 0, `INVALID_WORD, "unmapped read");
    send(2, 1'b0, 16'h0105, 0, 0, 0, `INVALID_WORD, "instruction region read");
    send(2, 1'b1, 16'h0123, instr, 4'hF, 0, 32'h0, "instruction write");
    @(posedge clk);
    #1;
    fetch_tile = 2'd2;
    fetch_pc = 8'h23;
    // fetch data is registered once
    @(posedge clk);
    @(negedge clk);
    check_value("fetched instruction", fetch_instr, instr);
  endtask

  task automatic busy_test();
    write_dmem(3, 8'h77, $urandom(), 4'hF);
    @(posedge clk);
    #1;
    busy[3] = 1'b1;
    send(0, 1'b0, `CSR_BASE + 1, 0, 0, 0, 32'(tgo_x_model[0]), "csr read beside busy tile");
    drive_req(3, 1'b0, 16'h0077, 0, 0, 0);
    for (int n = 0; n < busy_cycles_lp; n++) begin
      @(negedge clk);
      check_value("yumi_o while busy", 32'(yumi), 32'd0);
    end
    @(posedge clk);
    #1;
    busy[3] = 1'b0;
    wait_accept();
    check_rsp(3, dmem_model[3][8'h77], "held dmem read");
  endtask

  initial begin
    void'($urandom(67));
    reset = 1'b1;
    v = 1'b0;
    w = 1'b0;
    dest_tile = '0;
    addr = '0;
    data = '0;
    mask = '0;
    ld = '0;
    busy = '0;
    fetch_tile = '0;
    fetch_pc = '0;
    freeze_model = 4'hF;
    pending_model = '0;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;

    reset_state_test();
    dmem_word_test();
    load_ext_test();
    csr_test();
    invalid_and_icache_test();
    busy_test();

    repeat (4) @(posedge clk);
    report_counts();
    if (errors == 0 && tile_array_top_inst.tile_array_asserts_inst.fail_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

// ==== build.f ====
+incdir+verilog
verilog/manycore_pkg.sv
verilog/remote_req_if.sv
verilog/load_packer.sv
verilog/network_rx.sv
verilog/tile_endpoint.sv
verilog/req_dispatch.sv
verilog/rsp_collect.sv
verilog/tile_array_top.sv
testbench/tile_array_asserts.sv
testbench/tile_array_tb.sv
